// File: lpc_params.svh
// Build-time constants for the LPC snooper.
// Included by every module that sizes the window bank or decodes the register map.
`ifndef LPC_PARAMS_SVH
`define LPC_PARAMS_SVH

// Window bank size. LPC_WIN_BITS must be log2 of LPC_NUM_WINDOWS.
`define LPC_NUM_WINDOWS 4
`define LPC_WIN_BITS 2

// Word offsets inside a window's 8-word register block.
`define LPC_REG_BASE 0
`define LPC_REG_MASK 1
`define LPC_REG_CTRL 2
`define LPC_REG_ADDR 3
`define LPC_REG_INFO 4

`endif

// File: lpc_pkg.sv
// Shared types for the LPC snooper.
// Decoder, capture windows, register block and testbench all import this package.
package lpc_pkg;

	// Decoder FSM states.
	typedef enum logic [2:0] {
		idle      = 3'd0, // Waiting for START.
		cycle_dir = 3'd1, // Cycle type and direction nibble.
		address   = 3'd2, // Address nibbles, MSB first.
		tar       = 3'd3, // Turnaround before a read's sync.
		sync      = 3'd4, // Sync nibbles from the peripheral.
		data      = 3'd5  // Two data nibbles, low first.
	} lpc_state_e;

	// Cycle type, bits 3..2 of the cyctype/dir nibble.
	typedef enum logic [1:0] {
		cyc_io  = 2'b00,
		cyc_mem = 2'b01
	} lpc_cyctype_e;

	// One decoded transaction, 43 bits.
	typedef struct packed {
		lpc_cyctype_e cyctype;
		logic         write;   // 1 for host writes.
		logic [31:0]  addr;    // I/O addresses are zero-extended.
		logic [7:0]   data;
	} lpc_cycle_t;

	// Register write bus, shared by all windows.
	typedef struct packed {
		logic [2:0]  sel;  // Word offset inside the window.
		logic [31:0] data;
	} win_wr_t;

	// Readback of one window.
	typedef struct packed {
		logic [31:0] base;
		logic [31:0] mask;
		logic [31:0] ctrl;
		logic [31:0] last_addr;
		logic [31:0] info;
	} win_rd_t;

endpackage

// File: lpc_decoder.sv
// Passive LPC frame decoder.
// Samples lpc_ad and lpc_frame on the rising clock edge and emits one lpc_cycle_t
// per completed I/O or memory transaction, flagged by a single-cycle cycle_valid.
`timescale 1ns/10ps

module lpc_decoder (
	input  logic                lpc_clock,
	input  logic                lpc_reset,
	input  logic [3:0]          lpc_ad,
	input  logic                lpc_frame,
	output lpc_pkg::lpc_cycle_t cycle,
	output logic                cycle_valid
);
	import lpc_pkg::*;

	lpc_state_e   state;
	logic [2:0]   nib_cnt;   // Nibbles left in the current phase, minus one.
	lpc_cyctype_e cur_type;  // Type of the frame being decoded.
	logic         cur_write;
	logic [31:0]  addr_sr;   // Address shift register.
	logic [7:0]   data_sr;   // Data assembly, low nibble arrives first.
	logic         done;      // Last data nibble sampled on this edge.

	always_ff @(posedge lpc_clock) begin
		if (!lpc_reset) begin
			state       <= idle;
			nib_cnt     <= '0;
			done        <= 1'b0;
			cycle_valid <= 1'b0;
		end else begin
			done        <= 1'b0;
			cycle_valid <= done; // Publish one edge after the last nibble.
			if (!lpc_frame) begin
				// START restarts decoding anywhere, anything else aborts.
				nib_cnt <= '0;
				if (lpc_ad == 4'b0000)
					state <= cycle_dir;
				else
					state <= idle;
			end else begin
				case (state)
					idle: begin
						// Nothing to do until the next START.
					end
					cycle_dir: begin
						cur_type  <= lpc_cyctype_e'(lpc_ad[3:2]);
						cur_write <= lpc_ad[1];
						if (lpc_ad[3:2] == cyc_io) begin
							nib_cnt <= 3'd3; // 16-bit I/O address.
							state   <= address;
						end else if (lpc_ad[3:2] == cyc_mem) begin
							nib_cnt <= 3'd7; // 32-bit memory address.
							state   <= address;
						end else begin
							state <= idle; // DMA, bus master or reserved.
						end
					end
					address: begin
						addr_sr <= {addr_sr[27:0], lpc_ad};
						if (nib_cnt == 3'd0) begin
							nib_cnt <= 3'd1;
							// Writes carry data straight away, reads turn the bus around.
							state <= cur_write ? data : tar;
						end else begin
							nib_cnt <= nib_cnt - 3'd1;
						end
					end
					tar: begin
						if (nib_cnt == 3'd0)
							state <= sync;
						else
							nib_cnt <= nib_cnt - 3'd1;
					end
					sync: begin
						case (lpc_ad)
							4'b0000: begin // Ready.
								nib_cnt <= 3'd1;
								state   <= data;
							end
							4'b0101, 4'b0110: begin
								// Short or long wait, stay here.
							end
							default: state <= idle; // Error or no response.
						endcase
					end
					data: begin
						data_sr <= {lpc_ad, data_sr[7:4]};
						if (nib_cnt == 3'd0) begin
							done  <= 1'b1;
							state <= idle; // Trailing TAR is ignored.
						end else begin
							nib_cnt <= nib_cnt - 3'd1;
						end
					end
					default: state <= idle;
				endcase
			end
		end
	end

	// Output payload, updated together with the valid pulse.
	always_ff @(posedge lpc_clock) begin
		if (done) begin
			cycle.cyctype <= cur_type;
			cycle.write   <= cur_write;
			cycle.data    <= data_sr;
			if (cur_type == cyc_io)
				cycle.addr <= {16'h0000, addr_sr[15:0]}; // Zero-extend I/O.
			else
				cycle.addr <= addr_sr;
		end
	end

endmodule

// File: lpc_window.sv
// One capture window of the snooper.
// Holds base, mask and ctrl, compares each decoded cycle against them, and keeps
// the last matching transaction with a saturating hit count. Instantiated per window.
`timescale 1ns/10ps
`include "lpc_params.svh"

module lpc_window (
	input  logic                lpc_clock,
	input  logic                lpc_reset,
	input  lpc_pkg::lpc_cycle_t cycle,
	input  logic                cycle_valid,
	input  lpc_pkg::win_wr_t    wr,
	input  logic                we,
	input  logic                clr,
	output lpc_pkg::win_rd_t    rd,
	output logic                irq
);
	import lpc_pkg::*;

	logic [31:0]  base;
	logic [31:0]  mask;
	logic [31:0]  ctrl;      // 0 io, 1 mem, 2 read, 3 write, 4 irq_en.
	logic [31:0]  last_addr;
	logic         valid;
	logic [14:0]  hit_cnt;
	lpc_cyctype_e cap_type;
	logic         cap_write;
	logic [7:0]   cap_data;
	logic         type_ok, dir_ok, addr_ok, hit;

	assign type_ok = (cycle.cyctype == cyc_io  && ctrl[0]) ||
	                 (cycle.cyctype == cyc_mem && ctrl[1]);
	assign dir_ok  = cycle.write ? ctrl[3] : ctrl[2];
	assign addr_ok = ((cycle.addr ^ base) & mask) == 32'h0; // Only masked bits compare.
	assign hit     = cycle_valid && type_ok && dir_ok && addr_ok;

	always_ff @(posedge lpc_clock) begin
		if (!lpc_reset) begin
			base      <= '0;
			mask      <= '0;
			ctrl      <= '0;
			last_addr <= '0;
			valid     <= 1'b0;
			hit_cnt   <= '0;
			cap_type  <= cyc_io;
			cap_write <= 1'b0;
			cap_data  <= '0;
		end else begin
			if (we) begin
				case (wr.sel)
					`LPC_REG_BASE: base <= wr.data;
					`LPC_REG_MASK: mask <= wr.data;
					`LPC_REG_CTRL: ctrl <= wr.data;
					default: ; // Capture registers are read only.
				endcase
			end
			if (hit) begin
				last_addr <= cycle.addr;
				cap_type  <= cycle.cyctype;
				cap_write <= cycle.write;
				cap_data  <= cycle.data;
				valid     <= 1'b1; // Overrides a clear on the same edge.
				if (hit_cnt != 15'h7fff)
					hit_cnt <= hit_cnt + 15'd1; // Saturates.
			end else if (clr) begin
				valid <= 1'b0;
			end
		end
	end

	assign rd.base      = base;
	assign rd.mask      = mask;
	assign rd.ctrl      = ctrl;
	assign rd.last_addr = last_addr;
	assign rd.info      = {valid, hit_cnt, 2'b00, cap_type, 3'b000, cap_write, cap_data};

	assign irq = valid & ctrl[4]; // Unread capture with irq enabled.

endmodule

// File: lpc_wb_regs.sv
// Wishbone classic slave for the capture windows.
// wb_adr is a word address: bits 2..0 select the register, the next LPC_WIN_BITS
// bits the window, and the top two bits must be zero. Ack comes one cycle after
// the request; reading a window's info word clears its valid flag.
`timescale 1ns/10ps
`include "lpc_params.svh"

module lpc_wb_regs (
	input  logic                      lpc_clock,
	input  logic                      lpc_reset,
	input  logic                      wb_cyc,
	input  logic                      wb_stb,
	input  logic                      wb_we,
	input  logic [`LPC_WIN_BITS+4:0]  wb_adr,
	input  logic [31:0]               wb_dat_w,
	output logic [31:0]               wb_dat_r,
	output logic                      wb_ack,
	output lpc_pkg::win_wr_t          win_wr,
	output logic [`LPC_NUM_WINDOWS-1:0] win_we,
	output logic [`LPC_NUM_WINDOWS-1:0] win_clr,
	input  lpc_pkg::win_rd_t          win_rd [`LPC_NUM_WINDOWS]
);
	import lpc_pkg::*;

	logic [`LPC_WIN_BITS-1:0] win_idx;
	logic [2:0]               reg_off;
	logic                     mapped;  // Upper address bits are zero.
	logic                     req;     // New request, never back to back with ack.
	win_rd_t                  rd_sel;
	logic [31:0]              rd_word;

	assign win_idx = wb_adr[`LPC_WIN_BITS+2:3];
	assign reg_off = wb_adr[2:0];
	assign mapped  = (wb_adr[`LPC_WIN_BITS+4:`LPC_WIN_BITS+3] == 2'b00);
	assign req     = wb_cyc && wb_stb && !wb_ack;

	// Readback mux. Offsets 5 to 7 and unmapped addresses read zero.
	always_comb begin
		rd_sel  = win_rd[win_idx];
		rd_word = 32'h0;
		if (mapped) begin
			case (reg_off)
				`LPC_REG_BASE: rd_word = rd_sel.base;
				`LPC_REG_MASK: rd_word = rd_sel.mask;
				`LPC_REG_CTRL: rd_word = rd_sel.ctrl;
				`LPC_REG_ADDR: rd_word = rd_sel.last_addr;
				`LPC_REG_INFO: rd_word = rd_sel.info;
				default:       rd_word = 32'h0;
			endcase
		end
	end

	// Handshake and per-window strobes, all valid during the ack cycle.
	always_ff @(posedge lpc_clock) begin
		if (!lpc_reset) begin
			wb_ack  <= 1'b0;
			win_we  <= '0;
			win_clr <= '0;
		end else begin
			wb_ack  <= req;
			win_we  <= '0;
			win_clr <= '0;
			if (req && mapped) begin
				if (wb_we)
					win_we[win_idx] <= 1'b1; // Window applies it on the ack edge.
				else if (reg_off == `LPC_REG_INFO)
					win_clr[win_idx] <= 1'b1; // Read clears valid.
			end
		end
	end

	// Data paths.
	always_ff @(posedge lpc_clock) begin
		if (req) begin
			wb_dat_r    <= rd_word;
			win_wr.sel  <= reg_off;
			win_wr.data <= wb_dat_w;
		end
	end

endmodule

// File: lpc_snoop_top.sv
// Top level of the passive LPC snooper.
// Connects the decoder to a bank of capture windows programmed over Wishbone;
// irq is high while any irq-enabled window holds an unread capture.
`timescale 1ns/10ps
`include "lpc_params.svh"

module lpc_snoop_top (
	input  logic                     lpc_clock,
	input  logic                     lpc_reset,
	input  logic [3:0]               lpc_ad,
	input  logic                     lpc_frame,
	input  logic                     wb_cyc,
	input  logic                     wb_stb,
	input  logic                     wb_we,
	input  logic [`LPC_WIN_BITS+4:0] wb_adr,
	input  logic [31:0]              wb_dat_w,
	output logic [31:0]              wb_dat_r,
	output logic                     wb_ack,
	output logic                     irq
);
	import lpc_pkg::*;

	lpc_cycle_t                  cycle;
	logic                        cycle_valid;
	win_wr_t                     win_wr;
	logic [`LPC_NUM_WINDOWS-1:0] win_we;
	logic [`LPC_NUM_WINDOWS-1:0] win_clr;
	win_rd_t                     win_rd [`LPC_NUM_WINDOWS];
	logic [`LPC_NUM_WINDOWS-1:0] win_irq;

	lpc_decoder i_lpc_decoder (
		.lpc_clock   (lpc_clock),
		.lpc_reset   (lpc_reset),
		.lpc_ad      (lpc_ad),
		.lpc_frame   (lpc_frame),
		.cycle       (cycle),
		.cycle_valid (cycle_valid)
	);

	// Every window sees every cycle and the shared write bus.
	for (genvar i = 0; i < `LPC_NUM_WINDOWS; i++) begin : g_win
		lpc_window i_lpc_window (
			.lpc_clock   (lpc_clock),
			.lpc_reset   (lpc_reset),
			.cycle       (cycle),
			.cycle_valid (cycle_valid),
			.wr          (win_wr),
			.we          (win_we[i]),
			.clr         (win_clr[i]),
			.rd          (win_rd[i]),
			.irq         (win_irq[i])
		);
	end

	lpc_wb_regs i_lpc_wb_regs (
		.lpc_clock (lpc_clock),
		.lpc_reset (lpc_reset),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.win_wr    (win_wr),
		.win_we    (win_we),
		.win_clr   (win_clr),
		.win_rd    (win_rd)
	);

	assign irq = |win_irq; // Level, straight from window registers.

endmodule

// File: tb_lpc_tasks.svh
// Testbench helpers: LCG, LPC frame driving and Wishbone classic access.
// Included inside the testbench module body, works on its signals directly.
// Every task is entered and left 5 ns after a rising clock edge.
`ifndef TB_LPC_TASKS_SVH
`define TB_LPC_TASKS_SVH

// 32-bit LCG, low bits have short periods so callers use the upper ones.
function automatic logic [31:0] rand32();
	rng = rng * 32'd1664525 + 32'd1013904223;
	return rng;
endfunction

// One nibble, held for one clock.
task automatic lpc_nibble(input logic frame, input logic [3:0] ad);
	lpc_frame = frame;
	lpc_ad    = ad;
	@(posedge lpc_clock);
	#5;
endtask

task automatic lpc_idle(input int n);
	repeat (n) lpc_nibble(1'b1, 4'hf); // Ignored while no frame is open.
endtask

// START, then the cyctype/direction nibble.
task automatic lpc_start(input logic mem, input logic wr);
	lpc_nibble(1'b0, 4'h0);
	lpc_nibble(1'b1, {1'b0, mem, wr, 1'b0});
endtask

// Complete I/O or memory frame, reads with a number of sync waits.
task automatic lpc_frame_send(input logic mem, input logic wr, input logic [31:0] addr,
		input logic [7:0] dat, input int waits);
	lpc_start(mem, wr);
	for (int i = (mem ? 7 : 3); i >= 0; i--)
		lpc_nibble(1'b1, addr[i*4 +: 4]); // MSB first.
	if (!wr) begin
		lpc_nibble(1'b1, 4'hf); // TAR.
		lpc_nibble(1'b1, 4'hf);
		for (int i = 0; i < waits; i++)
			lpc_nibble(1'b1, (i % 2 == 0) ? 4'h5 : 4'h6); // Short and long waits.
		lpc_nibble(1'b1, 4'h0); // Sync ready.
	end
	lpc_nibble(1'b1, dat[3:0]);
	lpc_nibble(1'b1, dat[7:4]);
	lpc_idle(3); // Trailing TAR plus decoder and window latency.
endtask

// Classic single access; returns one clock after ack so writes and clears have landed.
task automatic wb_access(input logic we, input int win, input int off,
		input logic [31:0] wdat, output logic [31:0] rdat);
	int waited;
	wb_cyc   = 1'b1;
	wb_stb   = 1'b1;
	wb_we    = we;
	wb_adr   = {2'b00, win[`LPC_WIN_BITS-1:0], off[2:0]};
	wb_dat_w = wdat;
	waited   = 0;
	do begin
		@(posedge lpc_clock);
		#5;
		waited++;
	end while (!wb_ack);
	rdat = wb_dat_r;
	checks++;
	if (waited != 1) begin
		errors++;
		$display("wb_ack came %0d cycles after the request instead of 1", waited);
	end
	wb_cyc = 1'b0;
	wb_stb = 1'b0;
	wb_we  = 1'b0;
	@(posedge lpc_clock);
	#5;
	checks++;
	if (wb_ack !== 1'b0) begin
		errors++;
		$display("wb_ack stayed high for more than one cycle");
	end
endtask

`endif

// File: tb_lpc_snoop.sv
// Testbench for the LPC snooper top level.
// Drives random LPC frames and Wishbone accesses from a fixed LCG seed and
// compares window readback and irq with a model of the capture windows.
`timescale 1ns/10ps
`include "lpc_params.svh"

module tb_lpc_snoop;
	import lpc_pkg::*;

	localparam int NW = `LPC_NUM_WINDOWS;
	localparam int MAX_FRAMES = 60;  // Upper bound over all tests, 21 clocks each.
	localparam int MAX_WB = 260;     // Wishbone accesses, 3 clocks each.
	localparam int LIMIT = 4 * (MAX_FRAMES * 21 + MAX_WB * 3) + 10;

	logic                     lpc_clock;
	logic                     lpc_reset;
	logic [3:0]               lpc_ad;
	logic                     lpc_frame;
	logic                     wb_cyc;
	logic                     wb_stb;
	logic                     wb_we;
	logic [`LPC_WIN_BITS+4:0] wb_adr;
	logic [31:0]              wb_dat_w;
	logic [31:0]              wb_dat_r;
	logic                     wb_ack;
	logic                     irq;

	logic [31:0] rng;
	logic [31:0] rd_word; // Last Wishbone read.
	int          errors;
	int          checks;
	int          mark;
	int          cycles = 0;

	// Window model.
	logic [31:0] m_base [NW];
	logic [31:0] m_mask [NW];
	logic [31:0] m_ctrl [NW];
	logic [31:0] m_addr [NW];
	logic        m_valid [NW];
	logic [14:0] m_cnt [NW];
	logic [1:0]  m_type [NW];
	logic        m_write [NW];
	logic [7:0]  m_data [NW];

	lpc_snoop_top i_lpc_snoop_top (.*);

	`include "tb_lpc_tasks.svh"

	always #50 lpc_clock = ~lpc_clock;

	always @(posedge lpc_clock) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", LIMIT);
			$display("Test FAILED");
			$finish;
		end
	end

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	function automatic logic [31:0] exp_info(input int w);
		return {m_valid[w], m_cnt[w], 2'b00, m_type[w], 3'b000, m_write[w], m_data[w]};
	endfunction

	function automatic logic model_irq();
		logic any;
		any = 1'b0;
		for (int w = 0; w < NW; w++)
			any |= m_valid[w] & m_ctrl[w][4];
		return any;
	endfunction

	// Match rule applied to every window. I/O addresses arrive zero-extended.
	task automatic model_cycle(input logic mem, input logic wr, input logic [31:0] addr,
			input logic [7:0] dat);
		logic type_ok;
		logic dir_ok;
		for (int w = 0; w < NW; w++) begin
			type_ok = mem ? m_ctrl[w][1] : m_ctrl[w][0];
			dir_ok  = wr ? m_ctrl[w][3] : m_ctrl[w][2];
			if (type_ok && dir_ok && (addr & m_mask[w]) == (m_base[w] & m_mask[w])) begin
				m_addr[w]  = addr;
				m_valid[w] = 1'b1;
				m_type[w]  = mem ? 2'b01 : 2'b00;
				m_write[w] = wr;
				m_data[w]  = dat;
				if (m_cnt[w] != 15'h7fff)
					m_cnt[w] = m_cnt[w] + 15'd1;
			end
		end
	endtask

	task automatic reg_check(input int w, input int off, input logic [31:0] exp);
		wb_access(1'b0, w, off, 32'h0, rd_word);
		check($sformatf("wb_dat_r (window %0d, offset %0d)", w, off), exp, rd_word);
		if (off == `LPC_REG_INFO)
			m_valid[w] = 1'b0; // Read clears.
	endtask

	task automatic check_window(input int w);
		reg_check(w, `LPC_REG_ADDR, m_addr[w]);
		reg_check(w, `LPC_REG_INFO, exp_info(w));
	endtask

	task automatic cfg_window(input int w, input logic [31:0] b, input logic [31:0] m,
			input logic [31:0] c);
		wb_access(1'b1, w, `LPC_REG_BASE, b, rd_word);
		wb_access(1'b1, w, `LPC_REG_MASK, m, rd_word);
		wb_access(1'b1, w, `LPC_REG_CTRL, c, rd_word);
		m_base[w] = b;
		m_mask[w] = m;
		m_ctrl[w] = c;
	endtask

	// Address aimed at a random window, so hits and near misses both occur.
	task automatic random_frame();
		logic [31:0] r;
		logic [31:0] addr;
		int          k;
		r    = rand32();
		k    = int'(r[19:12]) % NW;
		addr = m_base[k] | (rand32() & ~m_mask[k]);
		if (!r[20])
			addr[31:16] = 16'h0; // I/O space.
		lpc_frame_send(r[20], r[21], addr, r[29:22], int'(r[31:30]));
		model_cycle(r[20], r[21], addr, r[29:22]);
	endtask

	task automatic test_done(input string name);
		$display("%s: %s, %0d errors", name, (errors == mark) ? "pass" : "fail", errors - mark);
	endtask

	initial begin
		lpc_clock = 1'b0;
		lpc_reset = 1'b0;
		lpc_ad    = 4'hf;
		lpc_frame = 1'b1;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_adr    = '0;
		wb_dat_w  = 32'h0;
		rng       = 32'h37b8a09d;
		errors    = 0;
		checks    = 0;
		for (int w = 0; w < NW; w++) begin
			m_base[w]  = 32'h0;
			m_mask[w]  = 32'h0;
			m_ctrl[w]  = 32'h0;
			m_addr[w]  = 32'h0;
			m_valid[w] = 1'b0;
			m_cnt[w]   = 15'h0;
			m_type[w]  = 2'b00;
			m_write[w] = 1'b0;
			m_data[w]  = 8'h0;
		end
		repeat (10) @(posedge lpc_clock);
		#5;
		lpc_reset = 1'b1;
		@(posedge lpc_clock);
		#5;

		// Reset state, then frames against unconfigured windows.
		mark = errors;
		check("wb_ack", 32'h0, 32'(wb_ack));
		check("irq", 32'h0, 32'(irq));
		for (int w = 0; w < NW; w++)
			for (int off = 0; off < 8; off++)
				reg_check(w, off, 32'h0);
		repeat (8) random_frame();
		for (int w = 0; w < NW; w++)
			check_window(w);
		test_done("test 1 reset and no capture");

		mark = errors;
		for (int w = 0; w < NW; w++)
			cfg_window(w, rand32(), rand32(), rand32());
		for (int w = 0; w < NW; w++) begin
			reg_check(w, `LPC_REG_BASE, m_base[w]);
			reg_check(w, `LPC_REG_MASK, m_mask[w]);
			reg_check(w, `LPC_REG_CTRL, m_ctrl[w]);
			for (int off = 5; off < 8; off++)
				reg_check(w, off, 32'h0);
		end
		test_done("test 2 register readback");

		// I/O and memory windows, each with an overlapping wider window.
		mark = errors;
		for (int w = 0; w < NW; w++) begin
			case (w % 4)
				0: cfg_window(w, rand32() & 32'h0000_fff0, 32'h0000_fff0, 32'h0d);
				1: cfg_window(w, rand32() & 32'hffff_ff00, 32'hffff_ff00, 32'h0e);
				2: cfg_window(w, m_base[w-2] & 32'h0000_ff00, 32'hffff_ff00, 32'h09);
				default: cfg_window(w, m_base[w-2] & 32'hffff_0000, 32'hffff_0000, 32'h06);
			endcase
		end
		repeat (10) begin
			repeat (4) random_frame();
			check("irq", 32'(model_irq()), 32'(irq));
			for (int w = 0; w < NW; w++)
				check_window(w);
		end
		test_done("test 3 random captures");

		// Window 0 matches everything, so any leak from a bad frame shows up.
		mark = errors;
		cfg_window(0, 32'h0, 32'h0, 32'h0f);
		for (int w = 0; w < NW; w++)
			check_window(w);
		lpc_start(1'b1, 1'b1);
		lpc_idle(2);
		lpc_nibble(1'b0, 4'h0); // New START mid frame.
		lpc_idle(10); // Enough to finish the first frame had it gone on.
		check_window(0);
		lpc_start(1'b0, 1'b1);
		lpc_idle(2);
		lpc_nibble(1'b0, 4'h5); // Frame low with a non-START nibble.
		lpc_idle(3);
		check_window(0);
		lpc_nibble(1'b0, 4'h0);
		lpc_nibble(1'b1, 4'b1010); // DMA write cycle type.
		lpc_idle(12); // A full memory write if it were taken as one.
		check_window(0);
		lpc_start(1'b0, 1'b0);
		lpc_idle(6); // Address and TAR.
		lpc_nibble(1'b1, 4'b1010); // Sync error.
		lpc_idle(5);
		check_window(0);
		random_frame();
		check_window(0);
		test_done("test 4 aborted frames");

		// Window 1 captures without irq_en, then window 0 with it.
		mark = errors;
		cfg_window(0, 32'h0, 32'h0, 32'h0);
		cfg_window(1, 32'h0, 32'h0, 32'h0f);
		for (int w = 2; w < NW; w++)
			cfg_window(w, 32'h0, 32'h0, 32'h0);
		random_frame();
		check("irq", 32'h0, 32'(irq));
		cfg_window(0, 32'h0, 32'h0, 32'h1f);
		random_frame();
		check("irq", 32'h1, 32'(irq));
		reg_check(1, `LPC_REG_INFO, exp_info(1));
		check("irq", 32'h1, 32'(irq));
		reg_check(0, `LPC_REG_INFO, exp_info(0));
		check("info valid", 32'h1, 32'(rd_word[31]));
		check("irq", 32'h0, 32'(irq));
		reg_check(0, `LPC_REG_INFO, exp_info(0));
		check("info valid", 32'h0, 32'(rd_word[31]));
		test_done("test 5 interrupt");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+.
lpc_pkg.sv
lpc_decoder.sv
lpc_window.sv
lpc_wb_regs.sv
lpc_snoop_top.sv
tb_lpc_snoop.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f verilog.f --top-module tb_lpc_snoop -Mdir obj_dir -o tb_lpc_snoop
	./obj_dir/tb_lpc_snoop | tee sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log
